// File: common/cache_params.svh
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// ------------------------------
// cache geometry
// ------------------------------

// word address, no byte offset bits.
`define CACHE_ADDR_SIZE 32

`define CACHE_NUM_SETS 16 // sets per way.

`define CACHE_NUM_WAYS 4 // associativity.

`define CACHE_BLOCK_WORDS 8 // words per block.

// ------------------------------
// datapath
// ------------------------------

`define CACHE_DATA_WIDTH 32 // width of one stored word.

`endif

// File: common/cache_pkg.sv
`include "cache_params.svh"

package cache_pkg;

  // ------------------------------
  // address fields
  // ------------------------------

  typedef logic [$clog2(`CACHE_BLOCK_WORDS)-1:0] offset_t; // word within block.

  typedef logic [$clog2(`CACHE_NUM_SETS)-1:0] set_t;

  // whatever is left above set and offset.
  typedef logic [`CACHE_ADDR_SIZE - $clog2(`CACHE_NUM_SETS)
                 - $clog2(`CACHE_BLOCK_WORDS) - 1:0] tag_t;

  typedef struct packed {
    tag_t    tag;
    set_t    set;
    offset_t offset;
  } cache_addr_t;

  // ------------------------------
  // ways and data
  // ------------------------------

  typedef logic [$clog2(`CACHE_NUM_WAYS)-1:0] way_t;

  typedef logic [`CACHE_NUM_WAYS-1:0] way_mask_t; // one bit per way.

  typedef logic [`CACHE_DATA_WIDTH-1:0] word_t;

  // kind of access, picked from we, hit and set occupancy.
  typedef enum logic [1:0] {
    ACC_READ          = 2'b00,
    ACC_WRITE_HIT     = 2'b01, // update in place.
    ACC_WRITE_FILL    = 2'b10, // take lowest free way.
    ACC_WRITE_REPLACE = 2'b11  // evict round-robin victim.
  } access_t;

endpackage

// File: common/lookup_if.sv
`timescale 1ns/1ps

interface lookup_if;
  import cache_pkg::*;

  set_t      set;
  tag_t      tag;
  way_mask_t hits;        // tag match and valid, per way.
  way_mask_t valid_flags;
  way_t      way;         // way chosen for this access.
  logic      alloc;       // write tag and valid at way.

  modport ctrl (
    output set, tag, way, alloc,
    input  hits, valid_flags
  );

  modport store (
    input  set, tag, way, alloc,
    output hits, valid_flags
  );

  // data side only needs the location and the fill strobe.
  modport data (
    input set, way, alloc
  );

endinterface

// File: cache_arrays/tag_store.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module tag_store (
  input logic     clk,
  input logic     rst_n,
  lookup_if.store lk
);
  import cache_pkg::*;

  // ------------------------------
  // storage
  // ------------------------------

  tag_t      tags  [`CACHE_NUM_SETS][`CACHE_NUM_WAYS];
  way_mask_t valid [`CACHE_NUM_SETS];

  way_mask_t set_valid;

  assign set_valid = valid[lk.set];

  // ------------------------------
  // lookup
  // ------------------------------

  // every way of the set compared at once.
  always_comb begin
    for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
      lk.hits[w] = set_valid[w] && (tags[lk.set][w] == lk.tag);
    end
  end

  assign lk.valid_flags = set_valid;

  // ------------------------------
  // update
  // ------------------------------

  always_ff @(posedge clk) begin
    if (lk.alloc) begin
      tags[lk.set][lk.way] <= lk.tag;
    end
  end

  // only reset clears a line.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < `CACHE_NUM_SETS; s++) begin
        valid[s] <= '0;
      end
    end else if (lk.alloc) begin
      valid[lk.set][lk.way] <= 1'b1;
    end
  end

endmodule

// File: cache_arrays/data_store.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module data_store (
  input  logic               clk,
  lookup_if.data             lk,
  input  cache_pkg::offset_t offset,
  input  logic               wr_en,
  input  logic               rd_en,
  input  cache_pkg::word_t   wdata,
  output cache_pkg::word_t   rdata
);
  import cache_pkg::*;

  word_t mem [`CACHE_NUM_SETS][`CACHE_NUM_WAYS][`CACHE_BLOCK_WORDS];

  // ------------------------------
  // write port
  // ------------------------------

  // a fill wipes the rest of the block in the same edge.
  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int k = 0; k < `CACHE_BLOCK_WORDS; k++) begin
        if (offset_t'(k) == offset) begin
          mem[lk.set][lk.way][k] <= wdata;
        end else if (lk.alloc) begin
          mem[lk.set][lk.way][k] <= '0;
        end
      end
    end
  end

  // ------------------------------
  // read port
  // ------------------------------

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rdata <= mem[lk.set][lk.way][offset];
    end else begin
      rdata <= '0; // misses and writes return zero.
    end
  end

endmodule

// File: design/replacement_unit.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module replacement_unit (
  input  logic            clk,
  input  logic            rst_n,
  input  cache_pkg::set_t set,
  input  logic            cru_enable,
  output cache_pkg::way_t replace_way
);
  import cache_pkg::*;

  way_t ptr [`CACHE_NUM_SETS]; // next victim, per set.

  assign replace_way = ptr[set];

  // ------------------------------
  // pointer advance
  // ------------------------------

  // width of way_t gives the wrap for free.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < `CACHE_NUM_SETS; s++) begin
        ptr[s] <= '0;
      end
    end else if (cru_enable) begin
      ptr[set] <= ptr[set] + way_t'(1);
    end
  end

endmodule

// File: design/cache_controller.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_controller (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req,
  input  logic                   we,
  input  cache_pkg::cache_addr_t addr,
  lookup_if.ctrl                 lk,
  input  cache_pkg::way_t        replace_way,
  output logic                   cru_enable,
  output cache_pkg::offset_t     offset,
  output logic                   wr_en,
  output logic                   rd_en,
  output logic                   rsp_valid,
  output logic                   rsp_hit,
  output cache_pkg::way_t        rsp_way
);
  import cache_pkg::*;

  logic    any_hit;
  logic    all_valid;
  way_t    hit_way;
  way_t    free_way;
  access_t kind;

  // ------------------------------
  // address split
  // ------------------------------

  assign lk.set = addr.set;
  assign lk.tag = addr.tag;
  assign offset = addr.offset;

  assign any_hit   = |lk.hits;
  assign all_valid = &lk.valid_flags;

  // ------------------------------
  // priority encodes
  // ------------------------------

  // walk down so the lowest set bit wins.
  always_comb begin
    hit_way = '0;
    for (int i = `CACHE_NUM_WAYS - 1; i >= 0; i--) begin
      if (lk.hits[i]) hit_way = way_t'(i);
    end
  end

  always_comb begin
    free_way = '0;
    for (int i = `CACHE_NUM_WAYS - 1; i >= 0; i--) begin
      if (!lk.valid_flags[i]) free_way = way_t'(i);
    end
  end

  // ------------------------------
  // classify and pick the way
  // ------------------------------

  always_comb begin
    if (!we) kind = ACC_READ;
    else if (any_hit) kind = ACC_WRITE_HIT;
    else if (!all_valid) kind = ACC_WRITE_FILL;
    else kind = ACC_WRITE_REPLACE;
  end

  always_comb begin
    case (kind)
      ACC_WRITE_FILL:    lk.way = free_way;
      ACC_WRITE_REPLACE: lk.way = replace_way;
      default:           lk.way = hit_way; // read miss falls to way 0.
    endcase
  end

  // strobes only fire on a real request.
  assign lk.alloc   = req && (kind == ACC_WRITE_FILL || kind == ACC_WRITE_REPLACE);
  assign cru_enable = req && (kind == ACC_WRITE_REPLACE);
  assign wr_en      = req && we;
  assign rd_en      = req && !we && any_hit;

  // ------------------------------
  // response register
  // ------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= req;
    end
  end

  // lookup state from before this edge's update.
  always_ff @(posedge clk) begin
    rsp_hit <= any_hit;
    rsp_way <= lk.way;
  end

endmodule

// File: design/cache_top.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_top (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                req,
  input  logic                                we,
  input  logic [`CACHE_ADDR_SIZE-1:0]         addr,
  input  logic [`CACHE_DATA_WIDTH-1:0]        wdata,
  output logic                                rsp_valid,
  output logic                                rsp_hit,
  output logic [$clog2(`CACHE_NUM_WAYS)-1:0]  rsp_way,
  output logic [`CACHE_DATA_WIDTH-1:0]        rdata
);
  import cache_pkg::*;

  way_t    replace_way;
  offset_t offset;
  logic    cru_enable;
  logic    wr_en;
  logic    rd_en;

  lookup_if lk ();

  // ------------------------------
  // control
  // ------------------------------

  cache_controller u_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .req         (req),
    .we          (we),
    .addr        (cache_addr_t'(addr)),
    .lk          (lk.ctrl),
    .replace_way (replace_way),
    .cru_enable  (cru_enable),
    .offset      (offset),
    .wr_en       (wr_en),
    .rd_en       (rd_en),
    .rsp_valid   (rsp_valid),
    .rsp_hit     (rsp_hit),
    .rsp_way     (rsp_way)
  );

  replacement_unit u_cru (
    .clk         (clk),
    .rst_n       (rst_n),
    .set         (lk.set),
    .cru_enable  (cru_enable),
    .replace_way (replace_way)
  );

  // ------------------------------
  // arrays
  // ------------------------------

  tag_store u_tags (
    .clk   (clk),
    .rst_n (rst_n),
    .lk    (lk.store)
  );

  data_store u_data (
    .clk    (clk),
    .lk     (lk.data),
    .offset (offset),
    .wr_en  (wr_en),
    .rd_en  (rd_en),
    .wdata  (word_t'(wdata)),
    .rdata  (rdata)
  );

endmodule

// File: sim/cache_sva.sv
`timescale 1ns/1ps

module cache_sva (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 req,
  input logic                 we,
  input cache_pkg::way_mask_t hits,
  input cache_pkg::way_mask_t valid_flags,
  input logic                 cru_enable,
  input logic                 rsp_valid
);

  // ------------------------------
  // response timing
  // ------------------------------

  a_rsp_after_req : assert property (
    @(posedge clk) disable iff (!rst_n) req |=> rsp_valid
  ) else $error("rsp_valid missing one cycle after req");

  a_no_rsp_without_req : assert property (
    @(posedge clk) disable iff (!rst_n) !req |=> !rsp_valid
  ) else $error("rsp_valid without a request in the cycle before");

  // async reset holds the response register clear.
  a_rsp_low_in_reset : assert property (
    @(posedge clk) !rst_n |-> !rsp_valid
  ) else $error("rsp_valid high during reset");

  // ------------------------------
  // lookup flags
  // ------------------------------

  a_hits_onehot : assert property (
    @(posedge clk) disable iff (!rst_n) $onehot0(hits)
  ) else $error("more than one way hits");

  a_cru_only_on_replace : assert property (
    @(posedge clk) disable iff (!rst_n)
      cru_enable |-> (we && (&valid_flags) && !(|hits))
  ) else $error("cru_enable outside a write miss to a full set");

endmodule

bind cache_controller cache_sva u_sva (
  .clk         (clk),
  .rst_n       (rst_n),
  .req         (req),
  .we          (we),
  .hits        (lk.hits),
  .valid_flags (lk.valid_flags),
  .cru_enable  (cru_enable),
  .rsp_valid   (rsp_valid)
);

// File: sim/cache_tb.sv
`timescale 1ns/1ps
`include "cache_params.svh"

module cache_tb;
  import cache_pkg::*;

  localparam int NUM_DIRECTED = 33;
  localparam int NUM_RANDOM   = 400;
  localparam int CYCLE_LIMIT  = 2 * (NUM_DIRECTED + NUM_RANDOM) + 100;

  typedef struct packed {
    logic        hit;
    logic        way_known; // read misses leave the way open.
    way_t        way;
    word_t       rdata;
    logic [31:0] due;
  } expect_t;

  logic        clk;
  logic        rst_n;
  logic        req;
  logic        we;
  logic [31:0] addr;
  logic [31:0] wdata;
  logic        rsp_valid;
  logic        rsp_hit;
  logic [1:0]  rsp_way;
  logic [31:0] rdata;

  expect_t     exp_q[$];
  int          cycles = 0;
  int          checks = 0;
  int          errors = 0;
  int          test_start_errors;
  logic [31:0] seed = 32'h2ee6_2f04;
  logic [31:0] rnd;

  // reference model state.
  tag_t  m_tag   [`CACHE_NUM_SETS][`CACHE_NUM_WAYS];
  logic  m_valid [`CACHE_NUM_SETS][`CACHE_NUM_WAYS];
  word_t m_data  [`CACHE_NUM_SETS][`CACHE_NUM_WAYS][`CACHE_BLOCK_WORDS];
  way_t  m_ptr   [`CACHE_NUM_SETS];

  cache_top uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .we        (we),
    .addr      (addr),
    .wdata     (wdata),
    .rsp_valid (rsp_valid),
    .rsp_hit   (rsp_hit),
    .rsp_way   (rsp_way),
    .rdata     (rdata)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, %0d responses outstanding", cycles, exp_q.size());
      $display("Test FAILED");
      $finish;
    end
  end

  // ------------------------------
  // reference model
  // ------------------------------

  function automatic cache_addr_t make_addr(tag_t t, set_t s, offset_t o);
    cache_addr_t a;
    a.tag    = t;
    a.set    = s;
    a.offset = o;
    return a;
  endfunction

  function automatic expect_t predict(logic wr, cache_addr_t a, word_t d);
    expect_t e;
    int      hw;
    int      fw;
    hw = -1;
    fw = -1;
    for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
      if (hw < 0 && m_valid[a.set][w] && m_tag[a.set][w] == a.tag) hw = w;
      if (fw < 0 && !m_valid[a.set][w]) fw = w;
    end
    e.hit       = (hw >= 0);
    e.way_known = wr || e.hit;
    e.way       = '0;
    e.rdata     = '0;
    e.due       = '0;
    if (!wr) begin
      if (e.hit) begin
        e.way   = way_t'(hw);
        e.rdata = m_data[a.set][hw][a.offset];
      end
    end else begin
      if (hw >= 0) e.way = way_t'(hw);
      else if (fw >= 0) e.way = way_t'(fw);
      else begin
        e.way = m_ptr[a.set];
        m_ptr[a.set] = m_ptr[a.set] + way_t'(1); // victim pointer moves on replace only.
      end
      if (hw < 0) begin
        m_tag[a.set][e.way]   = a.tag;
        m_valid[a.set][e.way] = 1'b1;
        for (int k = 0; k < `CACHE_BLOCK_WORDS; k++) m_data[a.set][e.way][k] = '0;
      end
      m_data[a.set][e.way][a.offset] = d;
    end
    return e;
  endfunction

  // ------------------------------
  // compare tasks
  // ------------------------------

  task automatic check_word(string name, word_t got, word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_way(string name, way_t got, way_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %s: got %h, expected %h", name, got, exp);
    end
  endtask

  always @(negedge clk) begin : compare
    expect_t e;
    if (rst_n) begin
      if (rsp_valid) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("response at cycle %0d with no request outstanding", cycles);
        end else begin
          e = exp_q.pop_front();
          if (e.due != cycles) begin
            errors++;
            $display("response at cycle %0d was due at cycle %0d", cycles, e.due);
          end
          check_bit("rsp_hit", rsp_hit, e.hit);
          if (e.way_known) check_way("rsp_way", rsp_way, e.way);
          check_word("rdata", rdata, e.rdata);
        end
      end else if (exp_q.size() != 0 && exp_q[0].due <= cycles) begin
        errors++;
        $display("no response for the request due at cycle %0d", exp_q[0].due);
        void'(exp_q.pop_front());
      end
    end
  end

  // ------------------------------
  // stimulus
  // ------------------------------

  task automatic issue(logic wr, cache_addr_t a, word_t d);
    expect_t e;
    e = predict(wr, a, d);
    e.due = cycles + 1;
    exp_q.push_back(e);
    req   = 1'b1;
    we    = wr;
    addr  = a;
    wdata = d;
    @(posedge clk);
    #1;
  endtask

  task automatic drain();
    req = 1'b0;
    we  = 1'b0;
    while (exp_q.size() != 0) @(posedge clk);
    #1;
  endtask

  task automatic finish_test(int num, string name);
    drain();
    $display("test %0d %s: %0d errors", num, name, errors - test_start_errors);
    test_start_errors = errors;
  endtask

  initial begin
    rst_n = 1'b0;
    req   = 1'b0;
    we    = 1'b0;
    addr  = '0;
    wdata = '0;
    test_start_errors = 0;
    for (int s = 0; s < `CACHE_NUM_SETS; s++) begin
      m_ptr[s] = '0;
      for (int w = 0; w < `CACHE_NUM_WAYS; w++) begin
        m_valid[s][w] = 1'b0;
        m_tag[s][w]   = '0;
        for (int k = 0; k < `CACHE_BLOCK_WORDS; k++) m_data[s][w][k] = '0;
      end
    end
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;

    for (int i = 0; i < 4; i++) issue(1'b0, make_addr(tag_t'(i + 1), set_t'(i), '0), '0);
    finish_test(1, "reads after reset");

    issue(1'b1, make_addr(5, 2, 3), 32'hcafe_0003);
    for (int k = 0; k < 8; k++) issue(1'b0, make_addr(5, 2, offset_t'(k)), '0);
    finish_test(2, "write then read back");

    for (int t = 0; t < 4; t++) issue(1'b1, make_addr(tag_t'(10 + t), 7, 0), word_t'(32'h3000 + t));
    for (int t = 0; t < 4; t++) issue(1'b0, make_addr(tag_t'(10 + t), 7, 0), '0);
    finish_test(3, "fill one set");

    issue(1'b1, make_addr(14, 7, 1), 32'h4000_000e);
    issue(1'b1, make_addr(15, 7, 1), 32'h4000_000f);
    for (int t = 10; t < 16; t++) issue(1'b0, make_addr(tag_t'(t), 7, 1), '0);
    finish_test(4, "round-robin replace");

    issue(1'b1, make_addr(13, 7, 0), 32'h5555_aaaa); // tag 13 still sits in way 3.
    issue(1'b0, make_addr(13, 7, 0), '0);
    issue(1'b1, make_addr(16, 7, 2), 32'h6000_0010);
    issue(1'b0, make_addr(16, 7, 2), '0);
    finish_test(5, "write hit in place");

    for (int i = 0; i < NUM_RANDOM; i++) begin
      rnd = $random(seed);
      issue(rnd[0], make_addr(tag_t'(rnd[8:6]), set_t'(rnd[5:4]), offset_t'(rnd[3:1])),
            $random(seed));
    end
    finish_test(6, "random traffic");

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: project.f
+incdir+common
common/cache_pkg.sv
common/lookup_if.sv
cache_arrays/tag_store.sv
cache_arrays/data_store.sv
design/replacement_unit.sv
design/cache_controller.sv
design/cache_top.sv
sim/cache_sva.sv
sim/cache_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = cache_tb
FILELIST = project.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = Test OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
